//--- hw/sram_test_defines.svh
/* geometry of the sram test chip and the bit layout of the scan packet
   depths must be powers of two no larger than 2**SRAM_ADDR_W */
`ifndef SRAM_TEST_DEFINES_SVH
`define SRAM_TEST_DEFINES_SVH

// memory geometry
`define SRAM_ADDR_W 9
`define SRAM_DATA_W 32
`define SRAM_MASK_W 4
`define SRAM_CHIPS 2
`define SRAM0_DEPTH 256
`define SRAM1_DEPTH 512

// total scan packet length
`define PKT_W 123

// field lsb positions, addr0 sits at the top
`define PKT_ADDR0_LSB 114
`define PKT_DIN0_LSB 82
`define PKT_CSB0_LSB 80
`define PKT_WEB0_LSB 79
`define PKT_WMASK0_LSB 75
`define PKT_ADDR1_LSB 66
`define PKT_CSB1_LSB 64
`define PKT_DATA0_LSB 32
`define PKT_DATA1_LSB 0

`endif

//--- hw/sram_test_pkg.sv
/* shared vector types and the sequencer state encoding
   widths come from the defines header */
`default_nettype none

`include "sram_test_defines.svh"

package sram_test_pkg;

   // one word address, shared by both ports
   typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

   // one data word
   typedef logic [`SRAM_DATA_W-1:0] sram_data_t;

   // byte enables, bit i covers byte i
   typedef logic [`SRAM_MASK_W-1:0] sram_mask_t;

   // active low selects, bit i selects memory i
   typedef logic [`SRAM_CHIPS-1:0] sram_csb_t;

   // access sequencer states
   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      CAPTURE
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/sram_macro.sv
/* behavioral 1rw1r memory standing in for a hard macro
   DEPTH must be a power of two, upper address bits are ignored
   no reset, contents and outputs start unknown */
`timescale 1ns/10ps
`default_nettype none

`include "sram_test_defines.svh"

module sram_macro #(
   parameter int DEPTH = 256
) (
   input  wire                       clk,
   // port 0, read or write
   input  wire                       csb0_i,
   input  wire                       web0_i,
   input  sram_test_pkg::sram_mask_t wmask0_i,
   input  sram_test_pkg::sram_addr_t addr0_i,
   input  sram_test_pkg::sram_data_t din0_i,
   output sram_test_pkg::sram_data_t dout0_o,
   // port 1, read only
   input  wire                       csb1_i,
   input  sram_test_pkg::sram_addr_t addr1_i,
   output sram_test_pkg::sram_data_t dout1_o
);

   import sram_test_pkg::*;

   localparam int IDX_W = $clog2(DEPTH);

   // storage array
   sram_data_t mem [DEPTH];

   // word index, address wraps at the depth
   logic [IDX_W-1:0] idx0_w;
   logic [IDX_W-1:0] idx1_w;

   assign idx0_w = IDX_W'(addr0_i);
   assign idx1_w = IDX_W'(addr1_i);

   // port 0
   always_ff @(posedge clk) begin
      if (!csb0_i) begin
         if (!web0_i) begin
            // masked byte write, dout0 keeps its last value
            for (int b = 0; b < `SRAM_MASK_W; b++) begin
               if (wmask0_i[b]) begin
                  mem[idx0_w][8*b +: 8] <= din0_i[8*b +: 8];
               end
            end
         end else begin
            // registered read, one cycle latency
            dout0_o <= mem[idx0_w];
         end
      end
   end

   // port 1
   always_ff @(posedge clk) begin
      // nonblocking read sees the word before a same-edge write
      if (!csb1_i) begin
         dout1_o <= mem[idx1_w];
      end
   end

   // write enable has to be clean whenever port 0 is selected
   a_web0_known: assert property (
      @(posedge clk) !csb0_i |-> !$isunknown(web0_i)
   ) else $error("sram_macro: web0 unknown while csb0 low");

endmodule

`default_nettype wire

//--- hw/scan_chain.sv
/* packet register, loaded serially from gpio or in parallel from the la bus
   in_select_i high picks gpio mode, low picks la mode
   shifting while capture_i is high is not allowed */
`timescale 1ns/10ps
`default_nettype none

`include "sram_test_defines.svh"

module scan_chain (
   input  wire                       clk,
   input  wire                       resetn,
   // mode and serial side
   input  wire                       in_select_i,
   input  wire                       scan_i,
   input  wire                       gpio_in_i,
   input  wire                       sram_load_i,
   output logic                      gpio_out_o,
   // parallel la side
   input  wire                       la_in_load_i,
   input  wire                       la_sram_load_i,
   input  wire  [`PKT_W-1:0]         la_data_i,
   output logic [`PKT_W-1:0]         la_data_o,
   // packet fields towards the sequencer
   output sram_test_pkg::sram_addr_t addr0_o,
   output sram_test_pkg::sram_data_t din0_o,
   output sram_test_pkg::sram_csb_t  csb0_o,
   output logic                      web0_o,
   output sram_test_pkg::sram_mask_t wmask0_o,
   output sram_test_pkg::sram_addr_t addr1_o,
   output sram_test_pkg::sram_csb_t  csb1_o,
   output logic                      go_o,
   // read results coming back
   input  wire                       capture_i,
   input  sram_test_pkg::sram_data_t data0_i,
   input  sram_test_pkg::sram_data_t data1_i
);

   logic [`PKT_W-1:0] pkt_q;
   logic [`PKT_W-1:0] pkt_d;

   // load strobe of the active mode
   logic load_sel_w;
   // previous samples for the edge detects
   logic load_sel_q;
   logic la_in_load_q;

   // a mode switch with the other strobe high can look like an edge
   assign load_sel_w = in_select_i ? sram_load_i : la_sram_load_i;

   always_comb begin
      pkt_d = pkt_q;
      if (in_select_i) begin
         // gpio mode, msb leaves first
         if (scan_i) begin
            pkt_d = {pkt_q[`PKT_W-2:0], gpio_in_i};
         end
      end else if (la_in_load_i && !la_in_load_q) begin
         // la mode, whole packet on the rising edge
         pkt_d = la_data_i;
      end
      // results overwrite only the two data fields
      if (capture_i) begin
         pkt_d[`PKT_DATA0_LSB +: `SRAM_DATA_W] = data0_i;
         pkt_d[`PKT_DATA1_LSB +: `SRAM_DATA_W] = data1_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         pkt_q        <= '0;
         load_sel_q   <= 1'b0;
         la_in_load_q <= 1'b0;
         go_o         <= 1'b0;
      end else begin
         pkt_q        <= pkt_d;
         load_sel_q   <= load_sel_w;
         la_in_load_q <= la_in_load_i;
         // single cycle pulse per rising strobe
         go_o         <= load_sel_w & ~load_sel_q;
      end
   end

   // observation ports
   assign gpio_out_o = pkt_q[`PKT_W-1];
   assign la_data_o  = pkt_q;

   // field decode
   assign addr0_o  = pkt_q[`PKT_ADDR0_LSB +: `SRAM_ADDR_W];
   assign din0_o   = pkt_q[`PKT_DIN0_LSB +: `SRAM_DATA_W];
   assign csb0_o   = pkt_q[`PKT_CSB0_LSB +: `SRAM_CHIPS];
   assign web0_o   = pkt_q[`PKT_WEB0_LSB];
   assign wmask0_o = pkt_q[`PKT_WMASK0_LSB +: `SRAM_MASK_W];
   assign addr1_o  = pkt_q[`PKT_ADDR1_LSB +: `SRAM_ADDR_W];
   assign csb1_o   = pkt_q[`PKT_CSB1_LSB +: `SRAM_CHIPS];

   // the sequencer result slot must not collide with a shift
   a_no_scan_on_capture: assert property (
      @(posedge clk) disable iff (!resetn) capture_i |-> !scan_i
   ) else $error("scan_chain: scan_i high during capture");

endmodule

`default_nettype wire

//--- hw/sram_test_ctrl.sv
/* runs one access per go pulse, go pulses while busy are dropped
   memories see active selects only in the ACCESS cycle
   results are valid together with capture_o, two cycles after go */
`timescale 1ns/10ps
`default_nettype none

`include "sram_test_defines.svh"

module sram_test_ctrl (
   input  wire                       clk,
   input  wire                       resetn,
   input  wire                       global_csb_i,
   input  wire                       go_i,
   // packet fields from the scan chain
   input  sram_test_pkg::sram_addr_t addr0_i,
   input  sram_test_pkg::sram_data_t din0_i,
   input  sram_test_pkg::sram_csb_t  csb0_i,
   input  wire                       web0_i,
   input  sram_test_pkg::sram_mask_t wmask0_i,
   input  sram_test_pkg::sram_addr_t addr1_i,
   input  sram_test_pkg::sram_csb_t  csb1_i,
   // shared memory port signals
   output sram_test_pkg::sram_addr_t sram_addr0_o,
   output sram_test_pkg::sram_data_t sram_din0_o,
   output logic                      sram_web0_o,
   output sram_test_pkg::sram_mask_t sram_wmask0_o,
   output sram_test_pkg::sram_addr_t sram_addr1_o,
   output sram_test_pkg::sram_csb_t  sram_csb0_o,
   output sram_test_pkg::sram_csb_t  sram_csb1_o,
   // read data of every memory
   input  sram_test_pkg::sram_data_t dout0_i [`SRAM_CHIPS],
   input  sram_test_pkg::sram_data_t dout1_i [`SRAM_CHIPS],
   // results towards the scan chain
   output logic                      capture_o,
   output sram_test_pkg::sram_data_t data0_o,
   output sram_test_pkg::sram_data_t data1_o
);

   import sram_test_pkg::*;

   ctrl_state_t state_q;
   ctrl_state_t state_d;

   // selects used by the last access, for result steering
   sram_csb_t sel0_q;
   sram_csb_t sel1_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE:    if (go_i) state_d = ACCESS;
         ACCESS:  state_d = CAPTURE;
         CAPTURE: state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= IDLE;
         sel0_q  <= '1;
         sel1_q  <= '1;
      end else begin
         state_q <= state_d;
         if (state_q == ACCESS) begin
            sel0_q <= sram_csb0_o;
            sel1_q <= sram_csb1_o;
         end
      end
   end

   // address and data go straight through, selects gate the access
   assign sram_addr0_o  = addr0_i;
   assign sram_din0_o   = din0_i;
   assign sram_web0_o   = web0_i;
   assign sram_wmask0_o = wmask0_i;
   assign sram_addr1_o  = addr1_i;

   // global_csb_i forces every memory off
   assign sram_csb0_o = (state_q == ACCESS && !global_csb_i) ? csb0_i : '1;
   assign sram_csb1_o = (state_q == ACCESS && !global_csb_i) ? csb1_i : '1;

   // outputs are one cycle behind the access, so CAPTURE is the slot
   assign capture_o = (state_q == CAPTURE);

   // lowest numbered selected memory wins, zero when none was selected
   always_comb begin
      data0_o = '0;
      data1_o = '0;
      for (int i = `SRAM_CHIPS - 1; i >= 0; i--) begin
         if (!sel0_q[i]) data0_o = dout0_i[i];
         if (!sel1_q[i]) data1_o = dout1_i[i];
      end
   end

   // no memory is touched outside the access slot
   a_csb_idle: assert property (
      @(posedge clk) disable iff (!resetn)
      (state_q != ACCESS) |-> (&sram_csb0_o && &sram_csb1_o)
   ) else $error("sram_test_ctrl: chip select low outside ACCESS");

   // a late go must not start a second access
   a_go_busy: assert property (
      @(posedge clk) disable iff (!resetn)
      (go_i && state_q != IDLE) |=> (state_q != ACCESS)
   ) else $error("sram_test_ctrl: go taken while busy");

endmodule

`default_nettype wire

//--- hw/sram_test_top.sv
/* sram test chip on a single clock, scan chain plus two 1rw1r memories
   memory 0 holds 256 words, memory 1 holds 512 words */
`timescale 1ns/10ps
`default_nettype none

`include "sram_test_defines.svh"

module sram_test_top (
   input  wire               clk,
   input  wire               resetn,
   input  wire               global_csb_i,
   input  wire               in_select_i,
   input  wire               scan_i,
   input  wire               gpio_in_i,
   input  wire               sram_load_i,
   input  wire               la_in_load_i,
   input  wire               la_sram_load_i,
   input  wire [`PKT_W-1:0]  la_data_i,
   output wire               gpio_out_o,
   output wire [`PKT_W-1:0]  la_data_o
);

   import sram_test_pkg::*;

   // packet fields out of the scan chain
   sram_addr_t pkt_addr0;
   sram_data_t pkt_din0;
   sram_csb_t  pkt_csb0;
   logic       pkt_web0;
   sram_mask_t pkt_wmask0;
   sram_addr_t pkt_addr1;
   sram_csb_t  pkt_csb1;

   // handshake and results
   logic       go;
   logic       capture;
   sram_data_t data0;
   sram_data_t data1;

   // memory side
   sram_addr_t mem_addr0;
   sram_data_t mem_din0;
   logic       mem_web0;
   sram_mask_t mem_wmask0;
   sram_addr_t mem_addr1;
   sram_csb_t  mem_csb0;
   sram_csb_t  mem_csb1;
   sram_data_t mem_dout0 [`SRAM_CHIPS];
   sram_data_t mem_dout1 [`SRAM_CHIPS];

   scan_chain u_scan (
      .clk            (clk),
      .resetn         (resetn),
      .in_select_i    (in_select_i),
      .scan_i         (scan_i),
      .gpio_in_i      (gpio_in_i),
      .sram_load_i    (sram_load_i),
      .gpio_out_o     (gpio_out_o),
      .la_in_load_i   (la_in_load_i),
      .la_sram_load_i (la_sram_load_i),
      .la_data_i      (la_data_i),
      .la_data_o      (la_data_o),
      .addr0_o        (pkt_addr0),
      .din0_o         (pkt_din0),
      .csb0_o         (pkt_csb0),
      .web0_o         (pkt_web0),
      .wmask0_o       (pkt_wmask0),
      .addr1_o        (pkt_addr1),
      .csb1_o         (pkt_csb1),
      .go_o           (go),
      .capture_i      (capture),
      .data0_i        (data0),
      .data1_i        (data1)
   );

   sram_test_ctrl u_ctrl (
      .clk           (clk),
      .resetn        (resetn),
      .global_csb_i  (global_csb_i),
      .go_i          (go),
      .addr0_i       (pkt_addr0),
      .din0_i        (pkt_din0),
      .csb0_i        (pkt_csb0),
      .web0_i        (pkt_web0),
      .wmask0_i      (pkt_wmask0),
      .addr1_i       (pkt_addr1),
      .csb1_i        (pkt_csb1),
      .sram_addr0_o  (mem_addr0),
      .sram_din0_o   (mem_din0),
      .sram_web0_o   (mem_web0),
      .sram_wmask0_o (mem_wmask0),
      .sram_addr1_o  (mem_addr1),
      .sram_csb0_o   (mem_csb0),
      .sram_csb1_o   (mem_csb1),
      .dout0_i       (mem_dout0),
      .dout1_i       (mem_dout1),
      .capture_o     (capture),
      .data0_o       (data0),
      .data1_o       (data1)
   );

   // memory 0, address wraps at 256
   sram_macro #(.DEPTH(`SRAM0_DEPTH)) u_sram0 (
      .clk      (clk),
      .csb0_i   (mem_csb0[0]),
      .web0_i   (mem_web0),
      .wmask0_i (mem_wmask0),
      .addr0_i  (mem_addr0),
      .din0_i   (mem_din0),
      .dout0_o  (mem_dout0[0]),
      .csb1_i   (mem_csb1[0]),
      .addr1_i  (mem_addr1),
      .dout1_o  (mem_dout1[0])
   );

   // memory 1, full 9 bit address
   sram_macro #(.DEPTH(`SRAM1_DEPTH)) u_sram1 (
      .clk      (clk),
      .csb0_i   (mem_csb0[1]),
      .web0_i   (mem_web0),
      .wmask0_i (mem_wmask0),
      .addr0_i  (mem_addr0),
      .din0_i   (mem_din0),
      .dout0_o  (mem_dout0[1]),
      .csb1_i   (mem_csb1[1]),
      .addr1_i  (mem_addr1),
      .dout1_o  (mem_dout1[1])
   );

endmodule

`default_nettype wire

//--- tb/tb_sram_test.sv
/* self-checking testbench for the sram test chip that drives the top level only
   expected data comes from a behavioral model of both memories
   memory words are only read after the test has written them */
`timescale 1ns/10ps
`default_nettype none

`include "sram_test_defines.svh"

module tb_sram_test;

   import sram_test_pkg::*;

   // run limit covers about 12 packets with a full shift in and out each
   localparam int TIMEOUT_CYCLES = 12 * (2 * `PKT_W + 10) + 500;
   // cycles allowed from load strobe to capture
   localparam int CAPTURE_WAIT = 8;
   localparam int IDX0_W = $clog2(`SRAM0_DEPTH);
   localparam int IDX1_W = $clog2(`SRAM1_DEPTH);

   // dut inputs
   logic              clk;
   logic              resetn;
   logic              global_csb_i;
   logic              in_select_i;
   logic              scan_i;
   logic              gpio_in_i;
   logic              sram_load_i;
   logic              la_in_load_i;
   logic              la_sram_load_i;
   logic [`PKT_W-1:0] la_data_i;
   // dut outputs
   wire               gpio_out_o;
   wire  [`PKT_W-1:0] la_data_o;

   // reference model holds storage plus the last read of each port
   sram_data_t mem0_m [`SRAM0_DEPTH];
   sram_data_t mem1_m [`SRAM1_DEPTH];
   sram_data_t rd0_m  [`SRAM_CHIPS];
   sram_data_t rd1_m  [`SRAM_CHIPS];

   // bookkeeping
   int    seed;
   int    errors;
   int    errors_at_start;
   int    tests_run;
   int    tests_failed;
   int    cycle_count;
   string test_name;

   // stimulus scratch
   logic [`PKT_W-1:0] pkt;
   logic [`PKT_W-1:0] got;
   logic [`PKT_W-1:0] exp_pkt;
   logic [31:0]       rnd;
   sram_data_t        word;
   sram_data_t        e0;
   sram_data_t        e1;
   sram_addr_t        addr;
   sram_addr_t        wr_addr [$];
   sram_mask_t        part_mask [$] = '{4'b0101, 4'b1000, 4'b0110};

   sram_test_top UUT (
      .clk            (clk),
      .resetn         (resetn),
      .global_csb_i   (global_csb_i),
      .in_select_i    (in_select_i),
      .scan_i         (scan_i),
      .gpio_in_i      (gpio_in_i),
      .sram_load_i    (sram_load_i),
      .la_in_load_i   (la_in_load_i),
      .la_sram_load_i (la_sram_load_i),
      .la_data_i      (la_data_i),
      .gpio_out_o     (gpio_out_o),
      .la_data_o      (la_data_o)
   );

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // hard stop on a hung run
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Errors found");
         $finish;
      end
   end

   // la strobe edge gives go one edge later
   a_strobe_go: assert property (@(posedge clk) disable iff (!resetn)
      (!in_select_i && $rose(la_sram_load_i)) |=> UUT.go)
   else begin
      errors++;
      $display("test %s: go did not follow the la load strobe", test_name);
   end

   // sequencer answers two cycles after go
   a_go_capture: assert property (@(posedge clk) disable iff (!resetn)
      UUT.capture |-> $past(UUT.go, 2))
   else begin
      errors++;
      $display("test %s: capture came without go two cycles before", test_name);
   end

   // global chip select keeps both memories idle
   a_global_off: assert property (@(posedge clk) disable iff (!resetn)
      global_csb_i |-> (&UUT.mem_csb0 && &UUT.mem_csb1))
   else begin
      errors++;
      $display("test %s: a memory was selected while global_csb_i was high", test_name);
   end

   task automatic begin_test(input string name);
      test_name = name;
      errors_at_start = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == errors_at_start) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d mismatches", test_name, errors - errors_at_start);
      end
   endtask

   task automatic check_word(input string what, input sram_data_t exp, input sram_data_t act);
      assert (act === exp) else begin
         errors++;
         $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_packet(input string what, input logic [`PKT_W-1:0] exp,
                               input logic [`PKT_W-1:0] act);
      assert (act === exp) else begin
         errors++;
         $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   // both result fields against the model
   task automatic check_fields(input logic [`PKT_W-1:0] act, input sram_data_t x0,
                               input sram_data_t x1);
      check_word("data0", x0, act[`PKT_DATA0_LSB +: `SRAM_DATA_W]);
      check_word("data1", x1, act[`PKT_DATA1_LSB +: `SRAM_DATA_W]);
   endtask

   // word index with the address taken modulo the depth
   function automatic logic [IDX0_W-1:0] idx0(input sram_addr_t a);
      return IDX0_W'(int'(a) % `SRAM0_DEPTH);
   endfunction

   function automatic logic [IDX1_W-1:0] idx1(input sram_addr_t a);
      return IDX1_W'(int'(a) % `SRAM1_DEPTH);
   endfunction

   // bytes with a set mask bit come from d and the rest stay
   function automatic sram_data_t merge_bytes(input sram_data_t old, input sram_data_t d,
                                              input sram_mask_t m);
      sram_data_t keep;
      keep = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
      return (old & ~keep) | (d & keep);
   endfunction

   // fields msb first with the data slots left at zero
   function automatic logic [`PKT_W-1:0] make_pkt(input sram_addr_t a0, input sram_data_t d0,
                                                  input sram_csb_t c0, input logic w0,
                                                  input sram_mask_t m0, input sram_addr_t a1,
                                                  input sram_csb_t c1);
      return {a0, d0, c0, w0, m0, a1, c1, {2 * `SRAM_DATA_W{1'b0}}};
   endfunction

   // one access on the model returning the expected data fields
   task automatic model_access(input logic [`PKT_W-1:0] p, input logic gcsb,
                               output sram_data_t x0, output sram_data_t x1);
      sram_addr_t a0;
      sram_addr_t a1;
      sram_data_t d0;
      sram_mask_t m0;
      sram_csb_t  s0;
      sram_csb_t  s1;
      logic       w0;
      a0 = p[`PKT_ADDR0_LSB +: `SRAM_ADDR_W];
      a1 = p[`PKT_ADDR1_LSB +: `SRAM_ADDR_W];
      d0 = p[`PKT_DIN0_LSB +: `SRAM_DATA_W];
      m0 = p[`PKT_WMASK0_LSB +: `SRAM_MASK_W];
      w0 = p[`PKT_WEB0_LSB];
      s0 = gcsb ? '1 : p[`PKT_CSB0_LSB +: `SRAM_CHIPS];
      s1 = gcsb ? '1 : p[`PKT_CSB1_LSB +: `SRAM_CHIPS];
      // port 1 goes first so it sees the word before a same cycle write
      if (!s1[0]) rd1_m[0] = mem0_m[idx0(a1)];
      if (!s1[1]) rd1_m[1] = mem1_m[idx1(a1)];
      // port 0 writes keep the last read word
      if (!s0[0]) begin
         if (w0) rd0_m[0] = mem0_m[idx0(a0)];
         else mem0_m[idx0(a0)] = merge_bytes(mem0_m[idx0(a0)], d0, m0);
      end
      if (!s0[1]) begin
         if (w0) rd0_m[1] = mem1_m[idx1(a0)];
         else mem1_m[idx1(a0)] = merge_bytes(mem1_m[idx1(a0)], d0, m0);
      end
      // lowest numbered selected memory wins and none gives zero
      x0 = !s0[0] ? rd0_m[0] : (!s0[1] ? rd0_m[1] : '0);
      x1 = !s1[0] ? rd1_m[0] : (!s1[1] ? rd1_m[1] : '0);
   endtask

   // raise the mode strobe then wait for capture and the field update
   task automatic load_and_wait(input logic gpio_mode);
      int n;
      n = 0;
      if (gpio_mode) sram_load_i = 1'b1;
      else la_sram_load_i = 1'b1;
      do begin
         @(negedge clk);
         n++;
      end while (!UUT.capture && n < CAPTURE_WAIT);
      if (!UUT.capture) begin
         errors++;
         $display("test %s: no capture within %0d cycles of the load strobe",
                  test_name, CAPTURE_WAIT);
      end
      sram_load_i = 1'b0;
      la_sram_load_i = 1'b0;
      // data fields change on the edge closing the capture cycle
      @(negedge clk);
   endtask

   // parallel load and run before reading back the register
   task automatic la_access(input logic [`PKT_W-1:0] p, output logic [`PKT_W-1:0] r,
                            output sram_data_t x0, output sram_data_t x1);
      model_access(p, global_csb_i, x0, x1);
      la_data_i = p;
      la_in_load_i = 1'b1;
      @(negedge clk);
      la_in_load_i = 1'b0;
      load_and_wait(1'b0);
      r = la_data_o;
   endtask

   // msb goes in first
   task automatic shift_in(input logic [`PKT_W-1:0] p);
      logic [`PKT_W-1:0] bits;
      bits = p;
      repeat (`PKT_W) begin
         scan_i = 1'b1;
         gpio_in_i = bits[`PKT_W-1];
         bits = bits << 1;
         @(negedge clk);
      end
      scan_i = 1'b0;
      gpio_in_i = 1'b0;
   endtask

   // msb comes out first and zeros fill behind
   task automatic shift_out(output logic [`PKT_W-1:0] r);
      r = '0;
      repeat (`PKT_W) begin
         r = {r[`PKT_W-2:0], gpio_out_o};
         scan_i = 1'b1;
         @(negedge clk);
      end
      scan_i = 1'b0;
   endtask

   initial begin
      seed = 32'h20d8;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      cycle_count = 0;
      test_name = "reset";
      resetn = 1'b0;
      global_csb_i = 1'b0;
      in_select_i = 1'b0;
      scan_i = 1'b0;
      gpio_in_i = 1'b0;
      sram_load_i = 1'b0;
      la_in_load_i = 1'b0;
      la_sram_load_i = 1'b0;
      la_data_i = '0;
      repeat (4) @(negedge clk);
      resetn = 1'b1;
      @(negedge clk);

      // clean reset and a blocked access
      begin_test("reset_and_global_off");
      check_packet("la_data_o", '0, la_data_o);
      check_word("gpio_out_o", '0, sram_data_t'(gpio_out_o));
      global_csb_i = 1'b1;
      pkt = make_pkt(9'd5, 32'h0, 2'b00, 1'b1, 4'h0, 9'd7, 2'b00);
      la_access(pkt, got, e0, e1);
      check_packet("la_data_o", pkt, got);
      check_fields(got, e0, e1);
      end_test();

      // random words into memory 0 with some bytes merged later
      begin_test("la_write_read");
      global_csb_i = 1'b0;
      repeat (6) begin
         rnd = $random(seed);
         addr = {1'b0, rnd[7:0]};
         word = $random(seed);
         wr_addr.push_back(addr);
         pkt = make_pkt(addr, word, 2'b10, 1'b0, 4'hf, 9'd0, 2'b11);
         la_access(pkt, got, e0, e1);
      end
      foreach (part_mask[j]) begin
         word = $random(seed);
         pkt = make_pkt(wr_addr[j], word, 2'b10, 1'b0, part_mask[j], 9'd0, 2'b11);
         la_access(pkt, got, e0, e1);
      end
      foreach (wr_addr[j]) begin
         pkt = make_pkt(wr_addr[j], 32'h0, 2'b10, 1'b1, 4'h0, 9'd0, 2'b11);
         la_access(pkt, got, e0, e1);
         check_fields(got, e0, e1);
      end
      end_test();

      // port 1 reads while port 0 writes
      begin_test("port1_during_write");
      word = $random(seed);
      pkt = make_pkt(9'd400, word, 2'b01, 1'b0, 4'hf, 9'd0, 2'b11);
      la_access(pkt, got, e0, e1);
      word = $random(seed);
      pkt = make_pkt(9'd17, word, 2'b10, 1'b0, 4'hf, 9'd400, 2'b01);
      la_access(pkt, got, e0, e1);
      check_fields(got, e0, e1);
      // same word on both ports where port 1 must see the old one
      word = $random(seed);
      pkt = make_pkt(wr_addr[0], word, 2'b10, 1'b0, 4'hf, wr_addr[0], 2'b10);
      la_access(pkt, got, e0, e1);
      check_fields(got, e0, e1);
      pkt = make_pkt(wr_addr[0], 32'h0, 2'b10, 1'b1, 4'h0, 9'd0, 2'b11);
      la_access(pkt, got, e0, e1);
      check_fields(got, e0, e1);
      end_test();

      // address 300 wraps to 44 in the smaller memory
      begin_test("address_wrap");
      word = $random(seed);
      pkt = make_pkt(9'd44, word, 2'b10, 1'b0, 4'hf, 9'd0, 2'b11);
      la_access(pkt, got, e0, e1);
      word = $random(seed);
      pkt = make_pkt(9'd300, word, 2'b01, 1'b0, 4'hf, 9'd0, 2'b11);
      la_access(pkt, got, e0, e1);
      pkt = make_pkt(9'd300, 32'h0, 2'b01, 1'b1, 4'h0, 9'd300, 2'b10);
      la_access(pkt, got, e0, e1);
      check_fields(got, e0, e1);
      end_test();

      // serial load and access followed by a serial readout
      begin_test("gpio_scan");
      in_select_i = 1'b1;
      pkt = make_pkt(wr_addr[1], 32'h0, 2'b10, 1'b1, 4'h0, 9'd300, 2'b01);
      // stale data slots that the capture overwrites
      pkt[`PKT_DATA0_LSB +: `SRAM_DATA_W] = $random(seed);
      pkt[`PKT_DATA1_LSB +: `SRAM_DATA_W] = $random(seed);
      model_access(pkt, global_csb_i, e0, e1);
      exp_pkt = pkt;
      exp_pkt[`PKT_DATA0_LSB +: `SRAM_DATA_W] = e0;
      exp_pkt[`PKT_DATA1_LSB +: `SRAM_DATA_W] = e1;
      shift_in(pkt);
      check_packet("la_data_o after shift", pkt, la_data_o);
      load_and_wait(1'b1);
      shift_out(got);
      check_packet("gpio stream", exp_pkt, got);
      in_select_i = 1'b0;
      end_test();

      // a write under global_csb is dropped
      begin_test("global_write_blocked");
      global_csb_i = 1'b1;
      word = $random(seed);
      pkt = make_pkt(wr_addr[2], word, 2'b10, 1'b0, 4'hf, wr_addr[2], 2'b10);
      la_access(pkt, got, e0, e1);
      check_fields(got, e0, e1);
      global_csb_i = 1'b0;
      pkt = make_pkt(wr_addr[2], 32'h0, 2'b10, 1'b1, 4'h0, 9'd0, 2'b11);
      la_access(pkt, got, e0, e1);
      check_fields(got, e0, e1);
      end_test();

      $display("summary: %0d tests, %0d failed, %0d mismatches",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/sram_test_pkg.sv
hw/sram_macro.sv
hw/scan_chain.sv
hw/sram_test_ctrl.sv
hw/sram_test_top.sv
tb/tb_sram_test.sv

//--- Makefile
# Verilator flow for the sram test chip testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
LINTFLAGS = --lint-only --timing --assert --timescale 1ns/10ps
TOP       = tb_sram_test
FILELIST  = build.f
OBJDIR    = obj_dir
PASS_MSG  = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
